// File: design/flow_mux_pkg.sv
// ----------------------------------------------------------------------
// Shared defaults and register map for the flow-controlled LRU mux.
// Import with a wildcard in the module header of any block that needs
// the default widths or the register address encoding.
// ----------------------------------------------------------------------

`default_nettype none

package flow_mux_pkg;

  // ----------------------------------------------------------------------
  // Default sizes, overridden from the top level
  // ----------------------------------------------------------------------

  // Number of requesters behind the mux
  parameter int num_req_dflt = 4;
  // Width of one data word
  parameter int data_w_dflt = 16;
  // Width of each grant counter, wraps at this size
  parameter int count_w_dflt = 8;

  // ----------------------------------------------------------------------
  // Register port
  // ----------------------------------------------------------------------

  parameter int cfg_addr_w = 4;
  // Also caps the requester count at 16, one enable bit each
  parameter int cfg_data_w = 16;

  // Register addresses
  // Counter i sits at reg_count0 + i, read only
  typedef enum logic [cfg_addr_w-1:0] {
    reg_enable = 4'd0,
    reg_clear  = 4'd1,
    reg_count0 = 4'd2
  } reg_addr_e;

endpackage : flow_mux_pkg

`default_nettype wire

// File: design/flow_arb_lru.sv
// ----------------------------------------------------------------------
// Least-recently-used arbiter with ready-valid flow control.
// Grants one valid requester per cycle from a priority order and moves
// the served index to the back of that order on each pop handshake.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module flow_arb_lru import flow_mux_pkg::*; #(
  // At least 2
  parameter int num_req = num_req_dflt
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [num_req-1:0] push_valid,
  output logic [num_req-1:0] push_ready,
  input  logic               pop_ready,
  output logic               pop_valid,
  // Onehot0 grant, not gated by pop_ready
  output logic [num_req-1:0] grant
);

  localparam int idx_w = (num_req > 1) ? $clog2(num_req) : 1;

  // ----------------------------------------------------------------------
  // Recency state
  // ----------------------------------------------------------------------

  // Position 0 is the most preferred requester
  // The last position holds the one served most recently
  logic [idx_w-1:0] order_q [num_req];
  logic [idx_w-1:0] order_d [num_req];

  // Position in the order of the winning requester
  logic [idx_w-1:0] grant_pos;
  logic             grant_found;
  logic             handshake;

  // ----------------------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------------------

  // Walk the order from the front
  // First valid requester found wins
  always_comb begin
    grant_found = 1'b0;
    grant_pos   = '0;
    grant       = '0;
    for (int p = 0; p < num_req; p++) begin
      if (!grant_found && push_valid[order_q[p]]) begin
        grant_found        = 1'b1;
        grant_pos          = idx_w'(p);
        grant[order_q[p]]  = 1'b1;
      end
    end
  end

  // Any valid request yields a grant
  assign pop_valid = grant_found;

  // Only the winner sees the consumer's ready
  assign push_ready = grant & {num_req{pop_ready}};

  assign handshake = pop_valid & pop_ready;

  // ----------------------------------------------------------------------
  // Order update
  // ----------------------------------------------------------------------

  // Entries behind the winner move up one place
  // Winner drops to the back, entries in front keep their place
  always_comb begin
    order_d = order_q;
    for (int p = 0; p < num_req - 1; p++) begin
      if (p >= int'(grant_pos)) begin
        order_d[p] = order_q[p+1];
      end
    end
    order_d[num_req-1] = order_q[grant_pos];
  end

  // Reset order is requester 0 first through num_req-1 last
  // Order only moves on a completed transfer, so back-pressure freezes it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < num_req; p++) begin
        order_q[p] <= idx_w'(p);
      end
    end else if (handshake) begin
      order_q <= order_d;
    end
  end

endmodule : flow_arb_lru

`default_nettype wire

// File: design/flow_mux_lru.sv
// ----------------------------------------------------------------------
// Flow-controlled mux with LRU arbitration, zero latency push to pop.
// Wraps the LRU arbiter, steers the granted word to the pop port and
// reports each pop handshake to the register block.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module flow_mux_lru import flow_mux_pkg::*; #(
  parameter int num_req = num_req_dflt,
  parameter int data_w  = data_w_dflt,
  localparam int idx_w  = (num_req > 1) ? $clog2(num_req) : 1
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [num_req-1:0]              push_valid,
  output logic [num_req-1:0]              push_ready,
  input  logic [num_req-1:0][data_w-1:0]  push_data,
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [data_w-1:0]               pop_data,
  output logic                            grant_fire,
  output logic [idx_w-1:0]                grant_idx
);

  // Ungated onehot0 grant from the arbiter
  logic [num_req-1:0] grant;

  flow_arb_lru #(
    .num_req (num_req)
  ) i_arb (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .grant      (grant)
  );

  // ----------------------------------------------------------------------
  // Grant index and data select
  // ----------------------------------------------------------------------

  // Onehot0 to binary, zero when nothing is granted
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < num_req; i++) begin
      if (grant[i]) begin
        grant_idx = idx_w'(i);
      end
    end
  end

  // Word of the winner, held steady while the consumer stalls
  assign pop_data = push_data[grant_idx];

  // One pulse per transfer for the grant counters
  assign grant_fire = pop_valid & pop_ready;

endmodule : flow_mux_lru

`default_nettype wire

// File: design/mux_regs.sv
// ----------------------------------------------------------------------
// Register block beside the LRU mux: requester enable mask plus one
// grant counter per requester. Plain write and read strobes, read data
// returns one cycle after the read strobe.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module mux_regs import flow_mux_pkg::*; #(
  parameter int num_req = num_req_dflt,
  parameter int count_w = count_w_dflt,
  localparam int idx_w  = (num_req > 1) ? $clog2(num_req) : 1
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cfg_wr,
  input  logic                  cfg_rd,
  input  reg_addr_e             cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata,
  output logic                  cfg_rvalid,
  input  logic                  grant_fire,
  input  logic [idx_w-1:0]      grant_idx,
  output logic [num_req-1:0]    enable
);

  logic [num_req-1:0] enable_q;
  logic [count_w-1:0] count_q [num_req];
  logic               clear;
  logic [cfg_data_w-1:0] rd_data;

  // ----------------------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------------------

  assign clear = cfg_wr && (cfg_addr == reg_clear);

  // Mask starts all ones so every requester is live out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable_q <= '1;
    end else if (cfg_wr && (cfg_addr == reg_enable)) begin
      enable_q <= cfg_wdata[num_req-1:0];
    end
  end

  assign enable = enable_q;

  // ----------------------------------------------------------------------
  // Grant counters
  // ----------------------------------------------------------------------

  // Clear beats a grant in the same cycle
  // Counters wrap at count_w bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_req; i++) begin
        count_q[i] <= '0;
      end
    end else if (clear) begin
      for (int i = 0; i < num_req; i++) begin
        count_q[i] <= '0;
      end
    end else if (grant_fire) begin
      count_q[grant_idx] <= count_q[grant_idx] + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------

  // Clear register and unknown addresses read as zero
  always_comb begin
    int cnt_sel;
    cnt_sel = int'(cfg_addr) - int'(reg_count0);
    rd_data = '0;
    if (cfg_addr == reg_enable) begin
      rd_data[num_req-1:0] = enable_q;
    end
    for (int i = 0; i < num_req; i++) begin
      if (cnt_sel == i) begin
        rd_data[count_w-1:0] = count_q[i];
      end
    end
  end

  // Read data is captured on the strobe and held until the next read
  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      cfg_rdata <= rd_data;
    end
  end

  // One-cycle qualifier for cfg_rdata
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_rd;
    end
  end

endmodule : mux_regs

`default_nettype wire

// File: design/flow_mux_top.sv
// ----------------------------------------------------------------------
// Top level of the LRU mux subsystem. Gates the requesters with the
// enable mask from the register block and sets the sizes for both.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module flow_mux_top import flow_mux_pkg::*; #(
  parameter int num_req = num_req_dflt,
  parameter int data_w  = data_w_dflt,
  parameter int count_w = count_w_dflt
) (
  input  logic                            clk,
  input  logic                            arst_n,
  // Requester side
  input  logic [num_req-1:0]              push_valid,
  output logic [num_req-1:0]              push_ready,
  input  logic [num_req-1:0][data_w-1:0]  push_data,
  // Consumer side
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output logic [data_w-1:0]               pop_data,
  // Register port
  input  logic                            cfg_wr,
  input  logic                            cfg_rd,
  input  reg_addr_e                       cfg_addr,
  input  logic [cfg_data_w-1:0]           cfg_wdata,
  output logic [cfg_data_w-1:0]           cfg_rdata,
  output logic                            cfg_rvalid
);

  localparam int idx_w = (num_req > 1) ? $clog2(num_req) : 1;

  logic [num_req-1:0] enable;
  logic [num_req-1:0] mux_push_valid;
  logic [num_req-1:0] mux_push_ready;
  logic               grant_fire;
  logic [idx_w-1:0]   grant_idx;

  // Disabled requesters are invisible to the arbiter and never see ready
  assign mux_push_valid = push_valid & enable;
  assign push_ready     = mux_push_ready & enable;

  flow_mux_lru #(
    .num_req (num_req),
    .data_w  (data_w)
  ) i_mux (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (mux_push_valid),
    .push_ready (mux_push_ready),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .grant_fire (grant_fire),
    .grant_idx  (grant_idx)
  );

  mux_regs #(
    .num_req (num_req),
    .count_w (count_w)
  ) i_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_wr     (cfg_wr),
    .cfg_rd     (cfg_rd),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_rvalid (cfg_rvalid),
    .grant_fire (grant_fire),
    .grant_idx  (grant_idx),
    .enable     (enable)
  );

endmodule : flow_mux_top

`default_nettype wire

// File: tb/flow_mux_assert.sv
// ----------------------------------------------------------------------
// Concurrent checks for the LRU mux subsystem, bound into the mux and
// into the register block. Ports unused at a bind site are tied low.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module flow_mux_assert import flow_mux_pkg::*; #(
  parameter int num_req = 4,
  parameter int data_w  = 16
) (
  input logic                           clk,
  input logic                           arst_n,
  input logic [num_req-1:0]             push_valid,
  input logic [num_req-1:0][data_w-1:0] push_data,
  input logic [num_req-1:0]             push_ready,
  input logic [num_req-1:0]             grant,
  input logic                           pop_ready,
  input logic                           pop_valid,
  input logic [data_w-1:0]              pop_data,
  input logic                           cfg_rd,
  input reg_addr_e                      cfg_addr,
  input logic [cfg_data_w-1:0]          cfg_rdata,
  input logic                           cfg_rvalid,
  input logic [num_req-1:0]             enable
);

  // At most one winner, ready only on the winner, pop_valid tracks the grant
  a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(grant) && ((push_ready & ~grant) == '0) && (pop_valid == (grant != '0)))
    else $error("grant not onehot0 or out of step with push_ready and pop_valid");

  // Stalled consumer with steady requesters sees a steady word and grant
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) ##1 ($stable(push_valid) && $stable(push_data))
    |-> pop_valid && $stable(grant) && $stable(pop_data))
    else $error("grant or pop_data moved while the consumer stalled");

  // Mask read returns one cycle after the strobe, with the mask seen at the strobe
  a_read_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (cfg_rd && (cfg_addr == reg_enable))
    |=> cfg_rvalid && (cfg_rdata[num_req-1:0] == $past(enable)))
    else $error("enable mask read data not returned one cycle after cfg_rd");

  a_rvalid_cause: assert property (@(posedge clk) disable iff (!arst_n)
    cfg_rvalid |-> $past(cfg_rd))
    else $error("cfg_rvalid without a read strobe the cycle before");

endmodule : flow_mux_assert

bind flow_mux_lru flow_mux_assert #(
  .num_req (num_req),
  .data_w  (data_w)
) i_assert_mux (
  .clk        (clk),
  .arst_n     (arst_n),
  .push_valid (push_valid),
  .push_data  (push_data),
  .push_ready (push_ready),
  .grant      (grant),
  .pop_ready  (pop_ready),
  .pop_valid  (pop_valid),
  .pop_data   (pop_data),
  .cfg_rd     (1'b0),
  .cfg_addr   (reg_enable),
  .cfg_rdata  ('0),
  .cfg_rvalid (1'b0),
  .enable     ('0)
);

bind mux_regs flow_mux_assert #(
  .num_req (num_req)
) i_assert_regs (
  .clk        (clk),
  .arst_n     (arst_n),
  .push_valid ('0),
  .push_data  ('0),
  .push_ready ('0),
  .grant      ('0),
  .pop_ready  (1'b0),
  .pop_valid  (1'b0),
  .pop_data   ('0),
  .cfg_rd     (cfg_rd),
  .cfg_addr   (cfg_addr),
  .cfg_rdata  (cfg_rdata),
  .cfg_rvalid (cfg_rvalid),
  .enable     (enable)
);

`default_nettype wire

// File: tb/tb_flow_mux.sv
// ----------------------------------------------------------------------
// Testbench for the LRU mux subsystem. Runs the line-based script in
// tb/flow_mux_tests.txt, models LRU order, enable mask and counters,
// and checks the pop port every cycle and every register read.
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_flow_mux import flow_mux_pkg::*; ();

  localparam int num_req    = num_req_dflt;
  localparam int data_w     = data_w_dflt;
  localparam int count_w    = count_w_dflt;
  localparam int rd_timeout = 8;

  logic                           clk;
  logic                           arst_n;
  logic [num_req-1:0]             push_valid;
  logic [num_req-1:0]             push_ready;
  logic [num_req-1:0][data_w-1:0] push_data;
  logic                           pop_ready;
  logic                           pop_valid;
  logic [data_w-1:0]              pop_data;
  logic                           cfg_wr;
  logic                           cfg_rd;
  reg_addr_e                      cfg_addr;
  logic [cfg_data_w-1:0]          cfg_wdata;
  logic [cfg_data_w-1:0]          cfg_rdata;
  logic                           cfg_rvalid;

  // ----------------------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------------------

  // Index 0 is the most preferred requester
  int                             mod_order [num_req];
  logic [num_req-1:0]             mod_en;
  logic [count_w-1:0]             mod_cnt [num_req];
  // Word each requester offers, renewed only once accepted
  logic [num_req-1:0][data_w-1:0] req_data;
  logic [31:0]                    lcg_state;
  int                             errors;
  int                             test_errors;
  int                             tests_passed;
  int                             tests_failed;
  string                          test_name;
  bit                             in_test;

  flow_mux_top #(
    .num_req (num_req),
    .data_w  (data_w),
    .count_w (count_w)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .cfg_wr     (cfg_wr),
    .cfg_rd     (cfg_rd),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_rvalid (cfg_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits make the better data word
  function automatic logic [data_w-1:0] fresh_word();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:16];
  endfunction

  function automatic logic [cfg_data_w-1:0] model_reg(input int addr);
    logic [cfg_data_w-1:0] v;
    v = '0;
    if (addr == int'(reg_enable)) begin
      v[num_req-1:0] = mod_en;
    end else if (addr >= int'(reg_count0) && addr < int'(reg_count0) + num_req) begin
      v[count_w-1:0] = mod_cnt[addr - int'(reg_count0)];
    end
    return v;
  endfunction

  function automatic string trim_eol(input string s);
    string t;
    t = s;
    while (t.len() > 0 && (t.getc(t.len() - 1) inside {"\n", "\r", " "})) begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  // Served requester goes to the back, the rest keep their relative order
  task automatic advance_order(input int win);
    int q[$];
    for (int p = 0; p < num_req; p++) begin
      if (mod_order[p] != win) begin
        q.push_back(mod_order[p]);
      end
    end
    q.push_back(win);
    for (int p = 0; p < num_req; p++) begin
      mod_order[p] = q[p];
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_pop(input logic exp_valid, input logic [data_w-1:0] exp_data,
                           input logic [num_req-1:0] exp_ready);
    if (pop_valid !== exp_valid) begin
      $display("ERROR %0t: pop_valid %b, expected %b", $time, pop_valid, exp_valid);
      count_error();
    end
    if (exp_valid && pop_data !== exp_data) begin
      $display("ERROR %0t: pop_data 0x%h, expected 0x%h", $time, pop_data, exp_data);
      count_error();
    end
    if (push_ready !== exp_ready) begin
      $display("ERROR %0t: push_ready %b, expected %b", $time, push_ready, exp_ready);
      count_error();
    end
  endtask

  task automatic check_reg(input reg_addr_e addr, input logic [cfg_data_w-1:0] exp);
    if (cfg_rdata !== exp) begin
      $display("ERROR %0t: register %0d read 0x%h, expected 0x%h",
               $time, addr, cfg_rdata, exp);
      count_error();
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus steps, all driven on the falling edge
  // ----------------------------------------------------------------------

  task automatic run_cycle(input logic [num_req-1:0] mask, input logic ready);
    logic [num_req-1:0] live;
    logic [num_req-1:0] exp_ready;
    logic               found;
    int                 win;
    @(negedge clk);
    cfg_wr     = 1'b0;
    push_valid = mask;
    push_data  = req_data;
    pop_ready  = ready;
    // Outputs are combinational, settle well before the rising edge
    #1;
    live  = mask & mod_en;
    found = 1'b0;
    win   = 0;
    for (int p = 0; p < num_req; p++) begin
      if (!found && live[mod_order[p]]) begin
        found = 1'b1;
        win   = mod_order[p];
      end
    end
    exp_ready = '0;
    if (found && ready) begin
      exp_ready[win] = 1'b1;
    end
    check_pop(found, req_data[win], exp_ready);
    if (found && ready) begin
      advance_order(win);
      mod_cnt[win] = mod_cnt[win] + 1'b1;
      req_data[win] = fresh_word();
    end
  endtask

  // Consumer stalls during register access so no grant slips in
  // The next step drops the strobe, so it runs in the cycle right after the write
  task automatic reg_write(input int addr, input logic [cfg_data_w-1:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = reg_addr_e'(addr);
    cfg_wdata = data;
    pop_ready = 1'b0;
    // Model takes the write now, the DUT at the coming rising edge
    if (addr == int'(reg_enable)) begin
      mod_en = data[num_req-1:0];
    end
    if (addr == int'(reg_clear)) begin
      for (int i = 0; i < num_req; i++) begin
        mod_cnt[i] = '0;
      end
    end
  endtask

  task automatic reg_read(input int addr, input logic [cfg_data_w-1:0] exp);
    int   waited;
    logic got;
    @(negedge clk);
    cfg_wr    = 1'b0;
    cfg_rd    = 1'b1;
    cfg_addr  = reg_addr_e'(addr);
    pop_ready = 1'b0;
    waited    = 0;
    got       = 1'b0;
    while (!got && waited < rd_timeout) begin
      @(negedge clk);
      cfg_rd = 1'b0;
      waited++;
      got = cfg_rvalid;
    end
    if (!got) begin
      $display("Timed out after %0d cycles waiting for read data from register %0d",
               rd_timeout, addr);
      count_error();
    end else begin
      if (waited != 1) begin
        $display("ERROR %0t: register %0d read data came %0d cycles after the strobe",
                 $time, addr, waited);
        count_error();
      end
      check_reg(reg_addr_e'(addr), exp);
    end
    if (model_reg(addr) !== exp) begin
      $display("The tests file expects 0x%h from register %0d but the model holds 0x%h",
               exp, addr, model_reg(addr));
      count_error();
    end
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("Test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // Line kinds are T name, C mask ready, W addr data, R addr expected
  task automatic process_line(input string line);
    string       rest;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    if (line.len() == 0) begin
      return;
    end
    kind = line.getc(0);
    rest = line.substr(2, line.len() - 1);
    case (kind)
      "#", "\n", "\r": begin
      end
      "T": begin
        if (in_test) begin
          finish_test();
        end
        test_name = trim_eol(rest);
        in_test   = 1'b1;
      end
      "C", "W", "R": begin
        n = $sscanf(rest, "%h %h", a, b);
        if (n != 2) begin
          $display("Malformed line in the tests file: %s", trim_eol(line));
          count_error();
        end else if (kind == "C") begin
          run_cycle(a[num_req-1:0], b[0]);
        end else if (kind == "W") begin
          reg_write(int'(a), b[cfg_data_w-1:0]);
        end else begin
          reg_read(int'(a), b[cfg_data_w-1:0]);
        end
      end
      default: begin
        $display("Unknown line kind in the tests file: %s", trim_eol(line));
        count_error();
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int    fd;
    string line;
    errors       = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    in_test      = 1'b0;
    arst_n       = 1'b0;
    push_valid   = '0;
    pop_ready    = 1'b0;
    cfg_wr       = 1'b0;
    cfg_rd       = 1'b0;
    cfg_addr     = reg_enable;
    cfg_wdata    = '0;
    lcg_state    = 32'hc699db2e;
    mod_en       = '1;
    for (int i = 0; i < num_req; i++) begin
      req_data[i]  = fresh_word();
      mod_order[i] = i;
      mod_cnt[i]   = '0;
    end
    push_data = req_data;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    fd = $fopen("tb/flow_mux_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/flow_mux_tests.txt for reading");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          process_line(line);
        end
      end
      $fclose(fd);
      if (in_test) begin
        finish_test();
      end
    end
    $display("Summary: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_flow_mux

`default_nettype wire

// File: tb/flow_mux_tests.txt
# T name | C push_valid_mask(hex) pop_ready | W addr(hex) data(hex) | R addr(hex) expected(hex)
# Register addresses: 0 enable mask, 1 clear, 2+i grant counter of requester i
T reset_values
R 0 000F
R 1 0000
R 2 0000
R 3 0000
R 4 0000
R 5 0000
T single_passthrough
C 1 1
C 1 0
C 1 1
C 4 1
R 2 0002
R 4 0001
T lru_rotation
C F 1
C F 1
C F 1
C F 1
C F 1
C 5 1
C 6 1
C A 1
C 0 1
R 2 0004
R 4 0003
T back_pressure
C 9 0
C 9 0
C 9 0
C 9 1
C F 1
R 3 0003
T enable_mask
W 0 0005
C F 1
C F 1
C A 1
R 0 0005
W 0 000F
C A 1
T counter_clear
R 2 0006
R 5 0003
W 1 0000
R 2 0000
R 4 0000
C 2 1
R 3 0001

// File: flist.f
design/flow_mux_pkg.sv
design/flow_arb_lru.sv
design/flow_mux_lru.sv
design/mux_regs.sv
design/flow_mux_top.sv
tb/flow_mux_assert.sv
tb/tb_flow_mux.sv
